/* rename.f */
+incdir+verilog
+incdir+bench
verilog/rename_pkg.sv
verilog/rename_if.sv
verilog/alias_table.sv
verilog/rob_alloc.sv
verilog/dec_intake.sv
verilog/rename_stage.sv
verilog/issue_out.sv
verilog/rename_top.sv
bench/rename_tb.sv

/* Makefile */
# Verilator build and run for the rename stage
VERILATOR ?= verilator
TOP       ?= rename_tb
LINT_TOP  ?= rename_top
FILELIST  ?= rename.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: run build lint clean

# the simulator exit status carries pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* bench/rename_cases.txt */
# kind name then hex fields; pair is v src0 src1 dst for slot 0 and slot 1, one exp line per slot
# exp: valid r0 rob0 data0 r1 rob1 data1 dst_rob dst; retire: per slot ret w_valid id rob check data
# after reset every source is committed
pair reset_rd 1 1 2 3 1 4 5 6
exp 1 1 0 0 1 0 0 0 3
exp 1 1 0 0 1 0 0 1 6
# unretired producers and the in-pair bypass
pair dep_pair 1 3 6 7 1 7 3 8
exp 1 0 0 0 0 1 0 2 7
exp 1 0 2 0 0 0 0 3 8
retire retire_a 1 1 3 0 1 11110003 1 1 6 1 1 22220006
# retired data and register 0
pair read_ret 1 3 6 0 1 0 3 0
exp 1 1 0 11110003 1 0 22220006 4 0
exp 1 1 0 0 1 0 11110003 5 0
# retire lands in the same cycle as the read
retnext same_cyc 1 1 7 2 1 33330007 0 0 0 0 0 0
pair bypass_rt 1 7 8 9 1 9 7 0
exp 1 1 0 33330007 0 3 0 6 9
exp 1 0 6 0 1 0 33330007 7 0
flush flush_a
# committed state survives, ids restart at 0
pair after_fl 1 3 7 7 1 9 7 3
exp 1 1 0 11110003 1 0 33330007 0 7
exp 1 1 0 0 0 0 0 1 3
retire retire_b 1 1 7 0 0 44440007 1 1 3 1 0 55550003
pair read_new 1 7 3 0 1 0 0 0
exp 1 1 0 44440007 1 0 55550003 2 0
exp 1 1 0 0 1 0 0 3 0
flush flush_b
# 31 pairs fill the buffer to 62, the next pair waits for two frees
fill fill_rob 1f
stall stall_full 8

/* bench/rename_tb_tasks.svh */
`ifndef RENAME_TB_TASKS_SVH
`define RENAME_TB_TASKS_SVH

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "run stopped");
endtask

task automatic check_value(input string name, input logic [255:0] exp, input logic [255:0] act);
    if (exp !== act) begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        $display("sim failed");
        $fatal(1, "value mismatch");
    end
endtask

function automatic rename_pkg::dec_slot_t make_dec(input logic [31:0] v, input logic [31:0] a,
                                                   input logic [31:0] b, input logic [31:0] d);
    rename_pkg::dec_slot_t s;
    s.valid = v[0];
    s.src0  = a[4:0];
    s.src1  = b[4:0];
    s.dst   = d[4:0];
    return s;
endfunction

// plain slot with register 0 everywhere, so every source is ready with data 0
function automatic rename_pkg::ren_slot_t zero_exp(input logic [5:0] rob);
    rename_pkg::ren_slot_t s;
    s         = '0;
    s.valid   = 1'b1;
    s.src0_ready = 1'b1;
    s.src1_ready = 1'b1;
    s.dst_rob = rob;
    return s;
endfunction

task automatic parse_exp(input string line, output rename_pkg::ren_slot_t s);
    string       k;
    logic [31:0] v [9];
    int          n;
    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", k, v[0], v[1], v[2], v[3], v[4],
                v[5], v[6], v[7], v[8]);
    if (n != 10 || k != "exp") begin
        fail_run({"malformed expected line: ", line});
    end
    s.valid      = v[0][0];
    s.src0_ready = v[1][0];
    s.src0_rob   = v[2][5:0];
    s.src0_data  = v[3];
    s.src1_ready = v[4][0];
    s.src1_rob   = v[5][5:0];
    s.src1_data  = v[6];
    s.dst_rob    = v[7][5:0];
    s.dst        = v[8][4:0];
endtask

task automatic wait_idle();
    while (exp_q.size() != 0) begin
        @(negedge clk);
    end
    repeat (2) @(negedge clk);
endtask

// handshake on decode, pending retire goes out in the cycle the pair fires
task automatic drive_pair(input rename_pkg::dec_slot_t [1:0] slots);
    logic acc;
    acc = 1'b0;
    @(negedge clk);
    dec_valid_i = 1'b1;
    dec_slot_i  = slots;
    while (!acc) begin
        #1;
        acc = dec_ready_o;
        @(negedge clk);
    end
    dec_valid_i     = 1'b0;
    c_retire_i      = pend_ret;
    c_retire_info_i = pend_info;
    if (pend_ret != 2'b00) begin
        pend_ret  = 2'b00;
        pend_info = '0;
        @(negedge clk);
        c_retire_i      = 2'b00;
        c_retire_info_i = '0;
    end
endtask

task automatic push_exp(input string name, input rename_pkg::ren_slot_t e0,
                        input rename_pkg::ren_slot_t e1);
    exp_q.push_back(e0);
    name_q.push_back({name, ".slot0"});
    exp_q.push_back(e1);
    name_q.push_back({name, ".slot1"});
endtask

task automatic send_pair(input string name, input rename_pkg::dec_slot_t [1:0] slots,
                         input rename_pkg::ren_slot_t e0, input rename_pkg::ren_slot_t e1);
    wait_idle();
    push_exp(name, e0, e1);
    drive_pair(slots);
    exp_rob = exp_rob + 6'(slots[0].valid) + 6'(slots[1].valid);
endtask

task automatic run_retire(input logic [1:0] ret, input rename_pkg::retire_t [1:0] info);
    wait_idle();
    @(negedge clk);
    c_retire_i      = ret;
    c_retire_info_i = info;
    @(negedge clk);
    c_retire_i      = 2'b00;
    c_retire_info_i = '0;
endtask

task automatic run_flush();
    wait_idle();
    @(negedge clk);
    c_flush_i = 1'b1;
    @(negedge clk);
    c_flush_i = 1'b0;
    exp_rob   = '0;
endtask

`endif

/* bench/rename_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_tb;

    logic                        clk = 1'b0;
    logic                        arst_n_i;
    logic                        dec_valid_i;
    rename_pkg::dec_slot_t [1:0] dec_slot_i;
    logic                        dec_ready_o;
    logic                        p_valid_o;
    rename_pkg::ren_slot_t [1:0] p_slot_o;
    logic                        p_ready_i;
    logic [1:0]                  c_retire_i;
    rename_pkg::retire_t [1:0]   c_retire_info_i;
    logic                        c_flush_i;

    rename_pkg::ren_slot_t       exp_q [$];
    string                       name_q [$];
    string                       lines [$];
    logic [31:0]                 lfsr;
    logic                        bit_a;
    logic                        bit_b;
    logic [5:0]                  exp_rob;
    logic [1:0]                  pend_ret;
    rename_pkg::retire_t [1:0]   pend_info;
    int                          cycles;
    int                          limit;

    `include "rename_tb_tasks.svh"

    rename_top uut (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .dec_valid_i     (dec_valid_i),
        .dec_slot_i      (dec_slot_i),
        .dec_ready_o     (dec_ready_o),
        .p_valid_o       (p_valid_o),
        .p_slot_o        (p_slot_o),
        .p_ready_i       (p_ready_i),
        .c_retire_i      (c_retire_i),
        .c_retire_info_i (c_retire_info_i),
        .c_flush_i       (c_flush_i)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic read_cases();
        int    fd;
        int    n;
        int    cnt;
        int    total;
        string line;
        string kind;
        string name;
        fd = $fopen("bench/rename_cases.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open bench/rename_cases.txt");
        end
        total = 0;
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0) begin
                break;
            end
            if (line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;
            end
            lines.push_back(line);
            cnt = 0;
            n = $sscanf(line, "%s %s %h", kind, name, cnt);
            if (kind == "fill") begin
                total += cnt;
            end else if (kind != "exp") begin
                total += 1;
            end
        end
        $fclose(fd);
        // reset and the closing idle wait get a little extra
        limit = 40 * (total + 2);
    endtask

    // next stage with random back-pressure about a quarter of the cycles
    always @(negedge clk) begin
        lfsr = lfsr_next(lfsr);
        bit_a = lfsr[0];
        lfsr = lfsr_next(lfsr);
        bit_b = lfsr[0];
        p_ready_i = ~(bit_a & bit_b);
        #1;
        if (arst_n_i && p_valid_o && p_ready_i) begin
            if (exp_q.size() < 2) begin
                fail_run("output pair appeared with nothing expected");
            end
            check_value(name_q[0], 256'(exp_q[0]), 256'(p_slot_o[0]));
            check_value(name_q[1], 256'(exp_q[1]), 256'(p_slot_o[1]));
            void'(exp_q.pop_front());
            void'(exp_q.pop_front());
            void'(name_q.pop_front());
            void'(name_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("run exceeded %0d cycles", limit);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    task automatic run_fill(input string name, input int pairs);
        rename_pkg::dec_slot_t [1:0] slots;
        slots = '0;
        slots[0].valid = 1'b1;
        slots[1].valid = 1'b1;
        wait_idle();
        for (int k = 0; k < pairs; k++) begin
            push_exp(name, zero_exp(exp_rob), zero_exp(exp_rob + 6'd1));
            drive_pair(slots);
            exp_rob = exp_rob + 6'd2;
        end
    endtask

    // buffer above its limit holds the pair until retires free entries
    task automatic run_stall(input string name, input int wait_cycles);
        rename_pkg::dec_slot_t [1:0] slots;
        slots = '0;
        slots[0].valid = 1'b1;
        slots[1].valid = 1'b1;
        wait_idle();
        push_exp(name, zero_exp(exp_rob), zero_exp(exp_rob + 6'd1));
        drive_pair(slots);
        exp_rob = exp_rob + 6'd2;
        repeat (wait_cycles) begin
            #1;
            check_value({name, ".dec_ready"}, 256'(1'b0), 256'(dec_ready_o));
            check_value({name, ".p_valid"}, 256'(1'b0), 256'(p_valid_o));
            @(negedge clk);
        end
        c_retire_i = 2'b11;
        @(negedge clk);
        c_retire_i = 2'b00;
    endtask

    initial begin
        string                       kind;
        string                       name;
        logic [31:0]                 f [12];
        int                          n;
        int                          idx;
        int                          settle;
        rename_pkg::dec_slot_t [1:0] slots;
        rename_pkg::ren_slot_t       e0;
        rename_pkg::ren_slot_t       e1;
        rename_pkg::retire_t [1:0]   info;
        logic [1:0]                  ret;
        arst_n_i        = 1'b0;
        dec_valid_i     = 1'b0;
        dec_slot_i      = '0;
        p_ready_i       = 1'b1;
        c_retire_i      = 2'b00;
        c_retire_info_i = '0;
        c_flush_i       = 1'b0;
        lfsr            = 32'h999e;
        exp_rob         = '0;
        pend_ret        = 2'b00;
        pend_info       = '0;
        cycles          = 0;
        limit           = 1000;
        read_cases();
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        #1;
        check_value("reset.dec_ready", 256'(1'b1), 256'(dec_ready_o));
        check_value("reset.p_valid", 256'(1'b0), 256'(p_valid_o));
        idx = 0;
        while (idx < lines.size()) begin
            n = $sscanf(lines[idx], "%s %s", kind, name);
            if (kind == "pair") begin
                n = $sscanf(lines[idx], "%s %s %h %h %h %h %h %h %h %h", kind, name,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                if (n != 10 || idx + 2 >= lines.size()) begin
                    fail_run({"malformed pair case: ", lines[idx]});
                end
                slots[0] = make_dec(f[0], f[1], f[2], f[3]);
                slots[1] = make_dec(f[4], f[5], f[6], f[7]);
                parse_exp(lines[idx+1], e0);
                parse_exp(lines[idx+2], e1);
                send_pair(name, slots, e0, e1);
                idx += 3;
            end else if (kind == "retire" || kind == "retnext") begin
                n = $sscanf(lines[idx], "%s %s %h %h %h %h %h %h %h %h %h %h %h %h", kind,
                            name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                            f[9], f[10], f[11]);
                if (n != 14) begin
                    fail_run({"malformed retire case: ", lines[idx]});
                end
                for (int i = 0; i < 2; i++) begin
                    ret[i]             = f[6*i][0];
                    info[i].w_valid    = f[6*i+1][0];
                    info[i].arf_id     = f[6*i+2][4:0];
                    info[i].rob_id     = f[6*i+3][5:0];
                    info[i].w_check    = f[6*i+4][0];
                    info[i].data       = f[6*i+5];
                end
                if (kind == "retire") begin
                    run_retire(ret, info);
                end else begin
                    // held back until the next pair fires
                    pend_ret  = ret;
                    pend_info = info;
                end
                idx += 1;
            end else if (kind == "flush") begin
                run_flush();
                idx += 1;
            end else if (kind == "fill" || kind == "stall") begin
                n = $sscanf(lines[idx], "%s %s %h", kind, name, f[0]);
                if (n != 3) begin
                    fail_run({"malformed count case: ", lines[idx]});
                end
                if (kind == "fill") begin
                    run_fill(name, int'(f[0]));
                end else begin
                    run_stall(name, int'(f[0]));
                end
                idx += 1;
            end else begin
                fail_run({"unknown case kind: ", lines[idx]});
            end
        end
        // give the last pairs a bounded time to reach the next stage
        settle = 0;
        while (exp_q.size() != 0 && settle < 40) begin
            @(negedge clk);
            settle++;
        end
        repeat (2) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("expected pairs never reached the next stage");
            $display("sim failed");
            $fatal(1, "pairs missing");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog/rename_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_top (
    input  logic                        clk,
    input  logic                        arst_n_i,
    // decode
    input  logic                        dec_valid_i,
    input  rename_pkg::dec_slot_t [1:0] dec_slot_i,
    output logic                        dec_ready_o,
    // next stage
    output logic                        p_valid_o,
    output rename_pkg::ren_slot_t [1:0] p_slot_o,
    input  logic                        p_ready_i,
    // commit
    input  logic [1:0]                  c_retire_i,
    input  rename_pkg::retire_t [1:0]   c_retire_info_i,
    input  logic                        c_flush_i
);

    logic                        space;
    logic [1:0]                  alloc;
    rename_pkg::ren_slot_t [1:0] ren_slot;
    logic                        ren_fire;
    logic                        out_ready;

    rename_if pair_if ();

    dec_intake u_intake (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (c_flush_i),
        .dec_valid_i (dec_valid_i),
        .dec_slot_i  (dec_slot_i),
        .dec_ready_o (dec_ready_o),
        .out_if      (pair_if)
    );

    // allocation base travels with the pair
    rob_alloc u_alloc (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (c_flush_i),
        .alloc_i  (alloc),
        .free_i   (c_retire_i),
        .base_o   (pair_if.rob_base),
        .space_o  (space)
    );

    rename_stage u_stage (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .flush_i       (c_flush_i),
        .in_if         (pair_if),
        .base_i        (pair_if.rob_base),
        .space_i       (space),
        .alloc_o       (alloc),
        .retire_i      (c_retire_i),
        .retire_info_i (c_retire_info_i),
        .out_slot_o    (ren_slot),
        .ren_fire_o    (ren_fire),
        .out_ready_i   (out_ready)
    );

    issue_out u_issue (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .flush_i    (c_flush_i),
        .in_slot_i  (ren_slot),
        .ren_fire_i (ren_fire),
        .ready_o    (out_ready),
        .p_valid_o  (p_valid_o),
        .p_slot_o   (p_slot_o),
        .p_ready_i  (p_ready_i)
    );

endmodule

`default_nettype wire

/* verilog/issue_out.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_out (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        flush_i,
    input  rename_pkg::ren_slot_t [1:0] in_slot_i,
    input  logic                        ren_fire_i,
    output logic                        ready_o,
    output logic                        p_valid_o,
    output rename_pkg::ren_slot_t [1:0] p_slot_o,
    input  logic                        p_ready_i
);

    rename_pkg::pipe_state_e     state_q;
    rename_pkg::pipe_state_e     state_d;
    rename_pkg::ren_slot_t [1:0] pair_q;
    logic                        drain;

    assign p_valid_o = (state_q != rename_pkg::EMPTY);
    assign drain     = p_valid_o & p_ready_i;
    // empty, or the held pair leaves this cycle
    assign ready_o   = (state_q == rename_pkg::EMPTY) | p_ready_i;

    always_comb begin
        state_d = state_q;
        if (ren_fire_i) begin
            state_d = rename_pkg::FULL;
        end else if (drain) begin
            state_d = rename_pkg::EMPTY;
        end else if (p_valid_o) begin
            state_d = rename_pkg::STALLED;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= rename_pkg::EMPTY;
        end else if (flush_i) begin
            state_q <= rename_pkg::EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (ren_fire_i) begin
            pair_q <= in_slot_i;
        end
    end

    assign p_slot_o = pair_q;

endmodule

`default_nettype wire

/* verilog/rename_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module rename_stage (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        flush_i,
    rename_if.receiver                  in_if,
    input  logic [`RN_ROB_ID_W-1:0]     base_i,
    input  logic                        space_i,
    output logic [1:0]                  alloc_o,
    input  logic [1:0]                  retire_i,
    input  rename_pkg::retire_t [1:0]   retire_info_i,
    output rename_pkg::ren_slot_t [1:0] out_slot_o,
    output logic                        ren_fire_o,
    input  logic                        out_ready_i
);

    localparam int unsigned ENTRY_W = $bits(rename_pkg::alias_entry_t);

    typedef logic [`RN_ROB_ID_W-1:0] rob_id_t;
    typedef logic [`RN_ARF_ID_W-1:0] arf_id_t;

    logic                           fire;
    logic                           slot0_writes;
    rob_id_t [1:0]                  dst_rob;
    arf_id_t [1:0]                  dst_id;
    logic [1:0]                     spec_we;
    rename_pkg::alias_entry_t [1:0] spec_new;
    arf_id_t                        src_id [4];
    arf_id_t                        commit_addr [6];
    rename_pkg::alias_entry_t       spec_rd [4];
    rename_pkg::alias_entry_t       commit_rd [6];
    logic [`RN_DATA_W-1:0]          arf_rd [4];
    logic [1:0]                     commit_we;
    arf_id_t [1:0]                  commit_id;
    rename_pkg::alias_entry_t [1:0] commit_new;
    logic [1:0][`RN_DATA_W-1:0]     commit_data;
    logic [`RN_ARF_DEPTH-1:0]       mapped_q;
    logic [3:0]                     src_byp;
    logic [3:0]                     src_ready;
    rob_id_t [3:0]                  src_rob;

    assign in_if.ready = space_i & out_ready_i & ~flush_i;
    assign fire        = in_if.valid & in_if.ready;
    assign ren_fire_o  = fire;

    assign dst_rob[0] = base_i;
    assign dst_rob[1] = base_i + rob_id_t'(alloc_o[0]);

    for (genvar i = 0; i < 2; i++) begin : g_slot
        assign alloc_o[i]            = fire & in_if.slot[i].valid;
        assign dst_id[i]             = in_if.slot[i].dst;
        assign spec_we[i]            = alloc_o[i] & (dst_id[i] != '0);
        // inverted check keeps a fresh mapping distinct from the committed one
        assign spec_new[i].check     = ~commit_rd[4+i].check;
        assign spec_new[i].rob_id    = dst_rob[i];
        assign src_id[2*i]           = in_if.slot[i].src0;
        assign src_id[2*i+1]         = in_if.slot[i].src1;
        assign commit_addr[2*i]      = in_if.slot[i].src0;
        assign commit_addr[2*i+1]    = in_if.slot[i].src1;
        assign commit_addr[4+i]      = dst_id[i];
        assign commit_we[i]          = retire_i[i] & retire_info_i[i].w_valid &
                                       (retire_info_i[i].arf_id != '0);
        assign commit_id[i]          = retire_info_i[i].arf_id;
        assign commit_new[i].check   = retire_info_i[i].w_check;
        assign commit_new[i].rob_id  = retire_info_i[i].rob_id;
        assign commit_data[i]        = retire_info_i[i].data;
    end

    // slot 1 sources see the slot 0 destination of the same pair
    assign slot0_writes = in_if.slot[0].valid & (dst_id[0] != '0);
    assign src_byp[0]   = 1'b0;
    assign src_byp[1]   = 1'b0;
    assign src_byp[2]   = slot0_writes & (src_id[2] == dst_id[0]);
    assign src_byp[3]   = slot0_writes & (src_id[3] == dst_id[0]);

    // registers renamed since the last flush
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mapped_q <= '0;
        end else if (flush_i) begin
            mapped_q <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (spec_we[i]) begin
                    mapped_q[dst_id[i]] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            src_ready[k] = (src_id[k] == '0) ||
                           (!src_byp[k] &&
                            (!mapped_q[src_id[k]] || (spec_rd[k] == commit_rd[k])));
            src_rob[k]   = src_byp[k] ? dst_rob[0] : spec_rd[k].rob_id;
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            out_slot_o[i].valid      = in_if.slot[i].valid;
            out_slot_o[i].src0_ready = src_ready[2*i];
            out_slot_o[i].src0_rob   = src_ready[2*i] ? '0 : src_rob[2*i];
            out_slot_o[i].src0_data  = src_ready[2*i] ? arf_rd[2*i] : '0;
            out_slot_o[i].src1_ready = src_ready[2*i+1];
            out_slot_o[i].src1_rob   = src_ready[2*i+1] ? '0 : src_rob[2*i+1];
            out_slot_o[i].src1_data  = src_ready[2*i+1] ? arf_rd[2*i+1] : '0;
            out_slot_o[i].dst_rob    = dst_rob[i];
            out_slot_o[i].dst        = dst_id[i];
        end
    end

    // speculative mappings, dropped on flush
    alias_table #(
        .DATA_WIDTH   (ENTRY_W),
        .R_PORTS      (4),
        .NEED_FORWARD (1'b0)
    ) spec_rat (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clear_i  (flush_i),
        .raddr_i  (src_id),
        .rdata_o  (spec_rd),
        .we_i     (spec_we),
        .waddr_i  (dst_id),
        .wdata_i  (spec_new)
    );

    // committed mappings, sources then destinations
    alias_table #(
        .DATA_WIDTH   (ENTRY_W),
        .R_PORTS      (6),
        .NEED_FORWARD (1'b1)
    ) commit_rat (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clear_i  (1'b0),
        .raddr_i  (commit_addr),
        .rdata_o  (commit_rd),
        .we_i     (commit_we),
        .waddr_i  (commit_id),
        .wdata_i  (commit_new)
    );

    alias_table #(
        .DATA_WIDTH   (`RN_DATA_W),
        .R_PORTS      (4),
        .NEED_FORWARD (1'b1)
    ) arf_file (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clear_i  (1'b0),
        .raddr_i  (src_id),
        .rdata_o  (arf_rd),
        .we_i     (commit_we),
        .waddr_i  (commit_id),
        .wdata_i  (commit_data)
    );

endmodule

`default_nettype wire

/* verilog/dec_intake.sv */
`timescale 1ns/1ps
`default_nettype none

module dec_intake (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        flush_i,
    input  logic                        dec_valid_i,
    input  rename_pkg::dec_slot_t [1:0] dec_slot_i,
    output logic                        dec_ready_o,
    rename_if.sender                    out_if
);

    rename_pkg::pipe_state_e     state_q;
    rename_pkg::pipe_state_e     state_d;
    rename_pkg::dec_slot_t [1:0] pair_q;
    logic                        take;
    logic                        leave;

    assign leave       = out_if.valid & out_if.ready;
    // refill in the cycle the held pair moves on
    assign dec_ready_o = ~flush_i & ((state_q == rename_pkg::EMPTY) | out_if.ready);
    assign take        = dec_valid_i & dec_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            rename_pkg::EMPTY: begin
                if (take) begin
                    state_d = rename_pkg::FULL;
                end
            end
            rename_pkg::FULL, rename_pkg::STALLED: begin
                if (leave) begin
                    state_d = take ? rename_pkg::FULL : rename_pkg::EMPTY;
                end else begin
                    state_d = rename_pkg::STALLED;
                end
            end
            default: state_d = rename_pkg::EMPTY;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= rename_pkg::EMPTY;
        end else if (flush_i) begin
            state_q <= rename_pkg::EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pair_q <= dec_slot_i;
        end
    end

    assign out_if.valid = (state_q != rename_pkg::EMPTY);
    assign out_if.slot  = pair_q;

endmodule

`default_nettype wire

/* verilog/rob_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module rob_alloc (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    flush_i,
    input  logic [1:0]              alloc_i,
    input  logic [1:0]              free_i,
    output logic [`RN_ROB_ID_W-1:0] base_o,
    output logic                    space_o
);

    // one extra bit so a full buffer of 64 fits
    localparam int unsigned CNT_W = `RN_ROB_ID_W + 1;

    typedef logic [CNT_W-1:0] cnt_t;

    cnt_t                    cnt_q;
    cnt_t                    cnt_d;
    cnt_t                    n_alloc;
    cnt_t                    n_free;
    logic [`RN_ROB_ID_W-1:0] ptr_q;
    logic                    space_q;

    assign n_alloc = cnt_t'(alloc_i[0]) + cnt_t'(alloc_i[1]);
    assign n_free  = cnt_t'(free_i[0]) + cnt_t'(free_i[1]);
    assign cnt_d   = cnt_q + n_alloc - n_free;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q   <= '0;
            ptr_q   <= '0;
            space_q <= 1'b1;
        end else if (flush_i) begin
            cnt_q   <= '0;
            ptr_q   <= '0;
            space_q <= 1'b1;
        end else begin
            cnt_q   <= cnt_d;
            // wraps modulo the buffer depth
            ptr_q   <= ptr_q + n_alloc[`RN_ROB_ID_W-1:0];
            space_q <= (cnt_q <= cnt_t'(`RN_ROB_LIMIT));
        end
    end

    assign base_o  = ptr_q;
    assign space_o = space_q;

endmodule

`default_nettype wire

/* verilog/alias_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module alias_table #(
    parameter int unsigned DATA_WIDTH   = 7,
    parameter int unsigned R_PORTS      = 4,
    parameter bit          NEED_FORWARD = 1'b0
) (
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    input  logic                                 clear_i,
    input  logic [`RN_ARF_ID_W-1:0]              raddr_i [R_PORTS],
    output logic [DATA_WIDTH-1:0]                rdata_o [R_PORTS],
    input  logic [1:0]                           we_i,
    input  logic [1:0][`RN_ARF_ID_W-1:0]         waddr_i,
    input  logic [1:0][DATA_WIDTH-1:0]           wdata_i
);

    localparam int unsigned DEPTH = `RN_ARF_DEPTH;

    logic [DATA_WIDTH-1:0] mem_q [DEPTH];

    // port 1 is written last so it wins on a shared address
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (clear_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            if (we_i[0]) begin
                mem_q[waddr_i[0]] <= wdata_i[0];
            end
            if (we_i[1]) begin
                mem_q[waddr_i[1]] <= wdata_i[1];
            end
        end
    end

    // reads, with same-cycle writes bypassed when enabled
    always_comb begin
        for (int r = 0; r < R_PORTS; r++) begin
            rdata_o[r] = mem_q[raddr_i[r]];
            if (NEED_FORWARD) begin
                if (we_i[0] && (waddr_i[0] == raddr_i[r])) begin
                    rdata_o[r] = wdata_i[0];
                end
                if (we_i[1] && (waddr_i[1] == raddr_i[r])) begin
                    rdata_o[r] = wdata_i[1];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/rename_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

// one decoded pair between intake and the rename logic
interface rename_if;

    logic                         valid;
    logic                         ready;
    rename_pkg::dec_slot_t [1:0]  slot;
    // allocation base, driven by the rob allocator at the top
    logic [`RN_ROB_ID_W-1:0]      rob_base;

    modport sender (
        output valid,
        output slot,
        input  ready
    );

    modport receiver (
        input  valid,
        input  slot,
        output ready
    );

endinterface

`default_nettype wire

/* verilog/rename_pkg.sv */
`default_nettype none

`include "rename_config.svh"

package rename_pkg;

    // one alias table entry, check bit over rob id
    typedef struct packed {
        logic                    check;
        logic [`RN_ROB_ID_W-1:0] rob_id;
    } alias_entry_t;

    // decoded slot from decode
    typedef struct packed {
        logic                    valid;
        logic [`RN_ARF_ID_W-1:0] src0;
        logic [`RN_ARF_ID_W-1:0] src1;
        logic [`RN_ARF_ID_W-1:0] dst;
    } dec_slot_t;

    // renamed slot toward the next stage
    typedef struct packed {
        logic                    valid;
        logic                    src0_ready;
        logic [`RN_ROB_ID_W-1:0] src0_rob;
        logic [`RN_DATA_W-1:0]   src0_data;
        logic                    src1_ready;
        logic [`RN_ROB_ID_W-1:0] src1_rob;
        logic [`RN_DATA_W-1:0]   src1_data;
        logic [`RN_ROB_ID_W-1:0] dst_rob;
        logic [`RN_ARF_ID_W-1:0] dst;
    } ren_slot_t;

    // one retiring instruction from commit
    typedef struct packed {
        logic                    w_valid;
        logic [`RN_ARF_ID_W-1:0] arf_id;
        logic [`RN_ROB_ID_W-1:0] rob_id;
        logic                    w_check;
        logic [`RN_DATA_W-1:0]   data;
    } retire_t;

    typedef enum logic [1:0] {
        EMPTY,
        FULL,
        STALLED
    } pipe_state_e;

endpackage

`default_nettype wire

/* verilog/rename_config.svh */
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural register file
`define RN_ARF_DEPTH 32
`define RN_ARF_ID_W 5

// reorder buffer
`define RN_ROB_DEPTH 64
`define RN_ROB_ID_W 6

// register data
`define RN_DATA_W 32

// occupancy above this stops allocation
// two pairs may still be in flight behind the registered flag
`define RN_ROB_LIMIT 60

`endif
